/* Bender.yml */
package:
  name: execCluster

sources:
  - include_dirs:
      - .
    files:
      - rvOpPkg.sv
      - rsPkg.sv
      - reservationStation.sv
      - aluExecute.sv
      - execCluster.sv
      - target: test
        files:
          - execCluster_tb.sv

/* aluExecute.sv */
`include "execCluster_defs.svh"

module aluExecute (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 issueEn,
    input  rvOpPkg::aluOp_e      issueOp,
    input  logic [`ADDR_W-1:0]   issuePc,
    input  logic [`DATA_W-1:0]   issueImm,
    input  logic [`NICK_W-1:0]   issueNick,
    input  logic [`DATA_W-1:0]   issueRs1,
    input  logic [`DATA_W-1:0]   issueRs2,
    // cdb
    output logic                 exEn,
    output logic [`NICK_W-1:0]   exNick,
    output logic [`DATA_W-1:0]   exData,
    output rvOpPkg::jumpFlag_e   exJump,   // rob only
    output logic [`ADDR_W-1:0]   exJumpPc  // rob only
);

    logic [`DATA_W-1:0]  resData;
    rvOpPkg::jumpFlag_e  resJump;
    logic [`ADDR_W-1:0]  resTarget;
    logic [`ADDR_W-1:0]  pcPlusImm;
    logic [`ADDR_W-1:0]  linkPc;
    logic [`DATA_W-1:0]  jalrSum;
    logic [4:0]          immShamt;
    logic [4:0]          regShamt;

    function automatic rvOpPkg::jumpFlag_e takeIf(input logic cond);
        return cond ? rvOpPkg::Jump : rvOpPkg::NotJump;
    endfunction

    assign pcPlusImm = issuePc + issueImm;
    assign linkPc    = issuePc + 4;
    assign jalrSum   = issueRs1 + issueImm;
    assign immShamt  = issueImm[4:0];
    assign regShamt  = issueRs2[4:0];

    // ----------------------------------------
    // decode
    always_comb begin
        resData   = '0;
        resJump   = rvOpPkg::NotJump;
        resTarget = pcPlusImm;  // branches and jal
        case (issueOp)
            rvOpPkg::LUI:   resData = issueImm;
            rvOpPkg::AUIPC: resData = pcPlusImm;
            rvOpPkg::JAL: begin
                resData = linkPc;
                resJump = rvOpPkg::Jump;
            end
            rvOpPkg::JALR: begin
                resData   = linkPc;
                resJump   = rvOpPkg::Jump;
                resTarget = {jalrSum[`ADDR_W-1:1], 1'b0};
            end
            rvOpPkg::BEQ:   resJump = takeIf(issueRs1 == issueRs2);
            rvOpPkg::BNE:   resJump = takeIf(issueRs1 != issueRs2);
            rvOpPkg::BLT:   resJump = takeIf($signed(issueRs1) < $signed(issueRs2));
            rvOpPkg::BGE:   resJump = takeIf($signed(issueRs1) >= $signed(issueRs2));
            rvOpPkg::BLTU:  resJump = takeIf(issueRs1 < issueRs2);
            rvOpPkg::BGEU:  resJump = takeIf(issueRs1 >= issueRs2);
            // immediate forms
            rvOpPkg::ADDI:  resData = jalrSum;
            rvOpPkg::SLTI:  resData = {{(`DATA_W-1){1'b0}}, $signed(issueRs1) < $signed(issueImm)};
            rvOpPkg::SLTIU: resData = {{(`DATA_W-1){1'b0}}, issueRs1 < issueImm};
            rvOpPkg::XORI:  resData = issueRs1 ^ issueImm;
            rvOpPkg::ORI:   resData = issueRs1 | issueImm;
            rvOpPkg::ANDI:  resData = issueRs1 & issueImm;
            rvOpPkg::SLLI:  resData = issueRs1 << immShamt;
            rvOpPkg::SRLI:  resData = issueRs1 >> immShamt;
            rvOpPkg::SRAI:  resData = $signed(issueRs1) >>> immShamt;
            // register forms
            rvOpPkg::ADD:   resData = issueRs1 + issueRs2;
            rvOpPkg::SUB:   resData = issueRs1 - issueRs2;
            rvOpPkg::SLL:   resData = issueRs1 << regShamt;
            rvOpPkg::SLT:   resData = {{(`DATA_W-1){1'b0}}, $signed(issueRs1) < $signed(issueRs2)};
            rvOpPkg::SLTU:  resData = {{(`DATA_W-1){1'b0}}, issueRs1 < issueRs2};
            rvOpPkg::XOR:   resData = issueRs1 ^ issueRs2;
            rvOpPkg::SRL:   resData = issueRs1 >> regShamt;
            rvOpPkg::SRA:   resData = $signed(issueRs1) >>> regShamt;
            rvOpPkg::OR:    resData = issueRs1 | issueRs2;
            rvOpPkg::AND:   resData = issueRs1 & issueRs2;
            default: ;
        endcase
    end

    // ----------------------------------------
    // result register
    always_ff @(posedge clk) begin
        if (rst) begin
            exEn <= 1'b0;
        end else if (rdy) begin
            exEn <= issueEn;  // one pulse per issue
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && issueEn) begin
            exNick   <= issueNick;
            exData   <= resData;
            exJump   <= resJump;
            exJumpPc <= resTarget;
        end
    end

    exEnNotRepeated: assert property (@(posedge clk) disable iff (rst)
        rdy && exEn |=> !exEn || exNick != $past(exNick))
        else $error("cdb result repeated without a new issue");

endmodule

/* execCluster.f */
+incdir+.
rvOpPkg.sv
rsPkg.sv
reservationStation.sv
aluExecute.sv
execCluster.sv
execCluster_tb.sv

/* execCluster.sv */
`include "execCluster_defs.svh"

module execCluster (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    // dispatch
    input  logic                 dispatchEn,
    input  rvOpPkg::aluOp_e      dispatchOp,
    input  logic [`ADDR_W-1:0]   dispatchPc,
    input  logic [`DATA_W-1:0]   dispatchImm,
    input  logic [`NICK_W-1:0]   dispatchNick,
    input  logic                 rs1Ready,
    input  rsPkg::operand_u      rs1Opnd,
    input  logic                 rs2Ready,
    input  rsPkg::operand_u      rs2Opnd,
    output logic                 rsFull,
    // load buffer broadcast
    input  logic                 extCdbEn,
    input  logic [`NICK_W-1:0]   extCdbNick,
    input  logic [`DATA_W-1:0]   extCdbData,
    // cdb toward the rob
    output logic                 exEn,
    output logic [`NICK_W-1:0]   exNick,
    output logic [`DATA_W-1:0]   exData,
    output rvOpPkg::jumpFlag_e   exJump,
    output logic [`ADDR_W-1:0]   exJumpPc
);

    logic                issueEn;
    rvOpPkg::aluOp_e     issueOp;
    logic [`ADDR_W-1:0]  issuePc;
    logic [`DATA_W-1:0]  issueImm;
    logic [`NICK_W-1:0]  issueNick;
    logic [`DATA_W-1:0]  issueRs1;
    logic [`DATA_W-1:0]  issueRs2;

    reservationStation i_reservationStation (
        .clk(clk), .rst(rst), .rdy(rdy),
        .dispatchEn(dispatchEn), .dispatchOp(dispatchOp), .dispatchPc(dispatchPc),
        .dispatchImm(dispatchImm), .dispatchNick(dispatchNick),
        .rs1Ready(rs1Ready), .rs1Opnd(rs1Opnd), .rs2Ready(rs2Ready), .rs2Opnd(rs2Opnd),
        .cdbEn(exEn), .cdbNick(exNick), .cdbData(exData),  // own results loop back
        .extCdbEn(extCdbEn), .extCdbNick(extCdbNick), .extCdbData(extCdbData),
        .rsFull(rsFull),
        .issueEn(issueEn), .issueOp(issueOp), .issuePc(issuePc), .issueImm(issueImm),
        .issueNick(issueNick), .issueRs1(issueRs1), .issueRs2(issueRs2)
    );

    aluExecute i_aluExecute (
        .clk(clk), .rst(rst), .rdy(rdy),
        .issueEn(issueEn), .issueOp(issueOp), .issuePc(issuePc), .issueImm(issueImm),
        .issueNick(issueNick), .issueRs1(issueRs1), .issueRs2(issueRs2),
        .exEn(exEn), .exNick(exNick), .exData(exData),
        .exJump(exJump), .exJumpPc(exJumpPc)
    );

endmodule

/* execCluster_defs.svh */
`ifndef EXEC_CLUSTER_DEFS_SVH
`define EXEC_CLUSTER_DEFS_SVH

// datapath widths
`define ADDR_W   32
`define DATA_W   32

// rename tag width, 16 rob slots
`define NICK_W   4

// reservation station entries, 2 or more
`define RS_DEPTH 4

`endif

/* execCluster_tb.sv */
`include "execCluster_defs.svh"

module execCluster_tb;

    localparam int timeoutCycles = 40;

    logic                 clk;
    logic                 rst;
    logic                 rdy;
    logic                 dispatchEn;
    rvOpPkg::aluOp_e      dispatchOp;
    logic [`ADDR_W-1:0]   dispatchPc;
    logic [`DATA_W-1:0]   dispatchImm;
    logic [`NICK_W-1:0]   dispatchNick;
    logic                 rs1Ready;
    rsPkg::operand_u      rs1Opnd;
    logic                 rs2Ready;
    rsPkg::operand_u      rs2Opnd;
    logic                 rsFull;
    logic                 extCdbEn;
    logic [`NICK_W-1:0]   extCdbNick;
    logic [`DATA_W-1:0]   extCdbData;
    logic                 exEn;
    logic [`NICK_W-1:0]   exNick;
    logic [`DATA_W-1:0]   exData;
    rvOpPkg::jumpFlag_e   exJump;
    logic [`ADDR_W-1:0]   exJumpPc;

    int                   errors = 0;
    int                   checks = 0;
    logic [31:0]          lcgState = 32'h743e8543;
    logic [`NICK_W-1:0]   nextNick = '0;
    logic [`DATA_W-1:0]   expData [2**`NICK_W];  // scoreboard by nick
    logic [2**`NICK_W-1:0] pending;
    int                   gotCount;

    execCluster i_execCluster (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic sLess(input logic [31:0] a, input logic [31:0] b);
        return (a[31] != b[31]) ? a[31] : (a < b);  // negative one is less when signs differ
    endfunction

    // ----------------------------------------
    // reference model
    function automatic void refModel(input rvOpPkg::aluOp_e op, input logic [31:0] pc,
            input logic [31:0] imm, input logic [31:0] a, input logic [31:0] b,
            output logic [31:0] d, output logic j, output logic [31:0] t);
        logic [63:0] wide;
        d = '0;
        j = 1'b0;
        t = pc + imm;
        case (op)
            rvOpPkg::LUI:   d = imm;
            rvOpPkg::AUIPC: d = pc + imm;
            rvOpPkg::JAL: begin
                d = pc + 32'd4;
                j = 1'b1;
            end
            rvOpPkg::JALR: begin
                d = pc + 32'd4;
                j = 1'b1;
                t = (a + imm) & 32'hFFFF_FFFE;
            end
            rvOpPkg::BEQ:   j = (a == b);
            rvOpPkg::BNE:   j = (a != b);
            rvOpPkg::BLT:   j = sLess(a, b);
            rvOpPkg::BGE:   j = !sLess(a, b);
            rvOpPkg::BLTU:  j = (a < b);
            rvOpPkg::BGEU:  j = !(a < b);
            rvOpPkg::ADDI:  d = a + imm;
            rvOpPkg::SLTI:  d = 32'(sLess(a, imm));
            rvOpPkg::SLTIU: d = 32'(a < imm);
            rvOpPkg::XORI:  d = a ^ imm;
            rvOpPkg::ORI:   d = a | imm;
            rvOpPkg::ANDI:  d = a & imm;
            rvOpPkg::SLLI:  d = a << imm[4:0];
            rvOpPkg::SRLI:  d = a >> imm[4:0];
            rvOpPkg::SRAI: begin
                wide = {{32{a[31]}}, a} >> imm[4:0];
                d = wide[31:0];
            end
            rvOpPkg::ADD:   d = a + b;
            rvOpPkg::SUB:   d = a - b;
            rvOpPkg::SLL:   d = a << b[4:0];
            rvOpPkg::SLT:   d = 32'(sLess(a, b));
            rvOpPkg::SLTU:  d = 32'(a < b);
            rvOpPkg::XOR:   d = a ^ b;
            rvOpPkg::SRL:   d = a >> b[4:0];
            rvOpPkg::SRA: begin
                wide = {{32{a[31]}}, a} >> b[4:0];
                d = wide[31:0];
            end
            rvOpPkg::OR:    d = a | b;
            rvOpPkg::AND:   d = a & b;
            default: ;
        endcase
    endfunction

    // ----------------------------------------
    task step();
        @(posedge clk);
        #10;
    endtask

    task checkVal(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    task dispatch(input rvOpPkg::aluOp_e op, input logic [31:0] pc, input logic [31:0] imm,
            input logic [`NICK_W-1:0] nick, input logic r1Rdy, input logic [31:0] r1,
            input logic r2Rdy, input logic [31:0] r2);
        dispatchEn   = 1'b1;
        dispatchOp   = op;
        dispatchPc   = pc;
        dispatchImm  = imm;
        dispatchNick = nick;
        rs1Ready     = r1Rdy;
        rs1Opnd      = r1;  // a tag when not ready
        rs2Ready     = r2Rdy;
        rs2Opnd      = r2;
        step();
        dispatchEn = 1'b0;
    endtask

    task checkCdb(input logic [`NICK_W-1:0] nick, input rvOpPkg::aluOp_e op,
            input logic [31:0] pc, input logic [31:0] imm, input logic [31:0] a,
            input logic [31:0] b);
        logic [31:0] d;
        logic [31:0] t;
        logic        j;
        refModel(op, pc, imm, a, b, d, j, t);
        checkVal("exNick", exNick, nick);
        checkVal("exData", exData, d);
        checkVal("exJump", exJump, j);
        if (j) checkVal("exJumpPc", exJumpPc, t);  // target only matters on a jump
    endtask

    task waitCdb(input logic [`NICK_W-1:0] nick, input rvOpPkg::aluOp_e op,
            input logic [31:0] pc, input logic [31:0] imm, input logic [31:0] a,
            input logic [31:0] b);
        int cnt;
        cnt = 0;
        while (!exEn && cnt < timeoutCycles) begin
            step();
            cnt++;
        end
        if (!exEn) begin
            $display("timed out waiting for the result of nick %0d", nick);
            errors++;
        end else begin
            checkCdb(nick, op, pc, imm, a, b);
            step();
        end
    endtask

    // both operands ready so the result lands on the second edge
    task runReady(input rvOpPkg::aluOp_e op, input logic [31:0] pc, input logic [31:0] imm,
            input logic [31:0] a, input logic [31:0] b);
        dispatch(op, pc, imm, nextNick, 1'b1, a, 1'b1, b);
        checkVal("exEn", exEn, 0);
        step();
        checkVal("exEn", exEn, 1);
        checkCdb(nextNick, op, pc, imm, a, b);
        nextNick++;
    endtask

    // scoreboard sample once per clock
    task tick();
        step();
        if (exEn) begin
            checks++;
            assert (pending[exNick]) else begin
                $display("result for nick %0d was not expected or came twice", exNick);
                errors++;
            end
            if (pending[exNick]) begin
                checkVal("exData", exData, expData[exNick]);
                pending[exNick] = 1'b0;
                gotCount++;
            end
        end
    endtask

    task broadcast(input logic [`NICK_W-1:0] nick, input logic [31:0] data);
        extCdbEn   = 1'b1;
        extCdbNick = nick;
        extCdbData = data;
        tick();
        extCdbEn = 1'b0;
    endtask

    // ----------------------------------------
    task resetQuiet();
        checkVal("exEn", exEn, 0);
        checkVal("rsFull", rsFull, 0);
        repeat (5) begin
            step();
            checkVal("exEn", exEn, 0);
        end
    endtask

    task aluResults();
        for (int k = 0; k < 29; k++) begin
            if (k < 2 || k > 9) begin  // skip jumps and branches
                repeat (2) runReady(rvOpPkg::aluOp_e'(k), nextRand(), nextRand(),
                    nextRand(), nextRand());
            end
        end
    endtask

    task branchOutcomes();
        logic [31:0] r;
        for (int k = 4; k <= 9; k++) begin
            r = nextRand();
            runReady(rvOpPkg::aluOp_e'(k), nextRand(), nextRand(), r, r);
            runReady(rvOpPkg::aluOp_e'(k), nextRand(), nextRand(), 32'hFFFF_FFF0, 32'h10);
            runReady(rvOpPkg::aluOp_e'(k), nextRand(), nextRand(), 32'h10, 32'hFFFF_FFF0);
            runReady(rvOpPkg::aluOp_e'(k), nextRand(), nextRand(), r, r + 32'd1);
        end
        repeat (2) begin
            runReady(rvOpPkg::JAL, nextRand(), nextRand(), nextRand(), nextRand());
            runReady(rvOpPkg::JALR, nextRand(), nextRand(), nextRand(), nextRand());
        end
    endtask

    task tagWakeup();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] x;
        logic [31:0] pc;
        logic [31:0] d;
        logic [31:0] t;
        logic        j;
        a  = nextRand();
        b  = nextRand();
        x  = nextRand();
        pc = nextRand();
        // rs1 waits on load buffer tag 9
        dispatch(rvOpPkg::ADD, pc, 32'd0, 4'd1, 1'b0, 32'd9, 1'b1, b);
        repeat (3) begin
            step();
            checkVal("exEn", exEn, 0);
        end
        extCdbEn   = 1'b1;
        extCdbNick = 4'd9;
        extCdbData = x;
        step();
        extCdbEn = 1'b0;
        waitCdb(4'd1, rvOpPkg::ADD, pc, 32'd0, x, b);
        // dependent pair through the internal cdb
        x = nextRand();
        dispatch(rvOpPkg::ADDI, pc, x, 4'd2, 1'b1, a, 1'b1, 32'd0);
        dispatch(rvOpPkg::SUB, pc, 32'd0, 4'd3, 1'b0, 32'd2, 1'b1, b);
        waitCdb(4'd2, rvOpPkg::ADDI, pc, x, a, 32'd0);
        refModel(rvOpPkg::ADDI, pc, x, a, 32'd0, d, j, t);
        waitCdb(4'd3, rvOpPkg::SUB, pc, 32'd0, d, b);
    endtask

    task fullStation();
        logic [31:0] tagData [`RS_DEPTH];
        logic [31:0] opB;
        logic [31:0] t;
        logic        j;
        int          cnt;
        pending  = '0;
        gotCount = 0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            opB = nextRand();
            tagData[i] = nextRand();
            refModel(rvOpPkg::ADD, 32'd0, 32'd0, tagData[i], opB, expData[4 + i], j, t);
            pending[4 + i] = 1'b1;
            dispatch(rvOpPkg::ADD, 32'd0, 32'd0, 4'(4 + i), 1'b0, 32'(12 + i), 1'b1, opB);
        end
        checkVal("rsFull", rsFull, 1);
        broadcast(4'd12, tagData[0]);
        cnt = 0;
        while (rsFull && cnt < timeoutCycles) begin
            tick();
            cnt++;
        end
        if (rsFull) begin
            $display("rsFull stayed high after one tag was resolved");
            errors++;
        end
        for (int i = 1; i < `RS_DEPTH; i++) broadcast(4'(12 + i), tagData[i]);
        cnt = 0;
        while (gotCount < `RS_DEPTH && cnt < timeoutCycles) begin
            tick();
            cnt++;
        end
        if (gotCount < `RS_DEPTH) begin
            $display("only %0d of %0d results appeared", gotCount, `RS_DEPTH);
            errors++;
        end
    endtask

    task rdyStall();
        logic [31:0] a;
        logic [31:0] b;
        a = nextRand();
        b = nextRand();
        dispatch(rvOpPkg::XOR, 32'd0, 32'd0, 4'd5, 1'b1, a, 1'b1, b);
        rdy = 1'b0;
        repeat (5) begin
            step();
            checkVal("exEn", exEn, 0);
        end
        rdy = 1'b1;
        waitCdb(4'd5, rvOpPkg::XOR, 32'd0, 32'd0, a, b);
        repeat (3) begin
            checkVal("exEn", exEn, 0);  // no second pulse
            step();
        end
    endtask

    // ----------------------------------------
    initial begin
        rst          = 1'b1;
        rdy          = 1'b1;
        dispatchEn   = 1'b0;
        dispatchOp   = rvOpPkg::ADD;
        dispatchPc   = '0;
        dispatchImm  = '0;
        dispatchNick = '0;
        rs1Ready     = 1'b0;
        rs1Opnd      = '0;
        rs2Ready     = 1'b0;
        rs2Opnd      = '0;
        extCdbEn     = 1'b0;
        extCdbNick   = '0;
        extCdbData   = '0;
        repeat (10) @(posedge clk);
        #10;
        rst = 1'b0;
        resetQuiet();
        aluResults();
        branchOutcomes();
        tagWakeup();
        fullStation();
        rdyStall();
        $display("errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* reservationStation.sv */
`include "execCluster_defs.svh"

module reservationStation (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    // dispatch
    input  logic                 dispatchEn,
    input  rvOpPkg::aluOp_e      dispatchOp,
    input  logic [`ADDR_W-1:0]   dispatchPc,
    input  logic [`DATA_W-1:0]   dispatchImm,
    input  logic [`NICK_W-1:0]   dispatchNick,
    input  logic                 rs1Ready,
    input  rsPkg::operand_u      rs1Opnd,
    input  logic                 rs2Ready,
    input  rsPkg::operand_u      rs2Opnd,
    // result buses
    input  logic                 cdbEn,
    input  logic [`NICK_W-1:0]   cdbNick,
    input  logic [`DATA_W-1:0]   cdbData,
    input  logic                 extCdbEn,
    input  logic [`NICK_W-1:0]   extCdbNick,
    input  logic [`DATA_W-1:0]   extCdbData,
    output logic                 rsFull,
    // to execute
    output logic                 issueEn,
    output rvOpPkg::aluOp_e      issueOp,
    output logic [`ADDR_W-1:0]   issuePc,
    output logic [`DATA_W-1:0]   issueImm,
    output logic [`NICK_W-1:0]   issueNick,
    output logic [`DATA_W-1:0]   issueRs1,
    output logic [`DATA_W-1:0]   issueRs2
);

    localparam int idxWidth = $clog2(`RS_DEPTH);

    rsPkg::rsEntry_s       entries [`RS_DEPTH];
    rsPkg::rsEntry_s       newEntry;
    logic [`RS_DEPTH-1:0]  busyVec;
    logic [idxWidth-1:0]   freeIdx;
    logic [idxWidth-1:0]   issueIdx;

    // tag hit on either bus
    function automatic logic cdbHit(input rsPkg::operand_u opnd);
        return (cdbEn && opnd.tag.nick == cdbNick) ||
               (extCdbEn && opnd.tag.nick == extCdbNick);
    endfunction

    // buses never carry the same nick together
    function automatic logic [`DATA_W-1:0] cdbValue(input rsPkg::operand_u opnd);
        return (cdbEn && opnd.tag.nick == cdbNick) ? cdbData : extCdbData;
    endfunction

    // ----------------------------------------
    // incoming entry captures a same-cycle broadcast
    always_comb begin
        newEntry.busy     = 1'b1;
        newEntry.op       = dispatchOp;
        newEntry.pc       = dispatchPc;
        newEntry.imm      = dispatchImm;
        newEntry.nick     = dispatchNick;
        newEntry.rs1Ready = rs1Ready;
        newEntry.rs1      = rs1Opnd;
        newEntry.rs2Ready = rs2Ready;
        newEntry.rs2      = rs2Opnd;
        if (!rs1Ready && cdbHit(rs1Opnd)) begin
            newEntry.rs1Ready = 1'b1;
            newEntry.rs1.data = cdbValue(rs1Opnd);
        end
        if (!rs2Ready && cdbHit(rs2Opnd)) begin
            newEntry.rs2Ready = 1'b1;
            newEntry.rs2.data = cdbValue(rs2Opnd);
        end
    end

    // ----------------------------------------
    // lowest free slot and lowest ready entry
    always_comb begin
        busyVec  = '0;
        freeIdx  = '0;
        issueEn  = 1'b0;
        issueIdx = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin  // downward so the lowest wins
            busyVec[i] = entries[i].busy;
            if (!entries[i].busy) begin
                freeIdx = idxWidth'(i);
            end else if (entries[i].rs1Ready && entries[i].rs2Ready) begin
                issueEn  = 1'b1;
                issueIdx = idxWidth'(i);
            end
        end
    end

    assign rsFull = &busyVec;

    assign issueOp   = entries[issueIdx].op;
    assign issuePc   = entries[issueIdx].pc;
    assign issueImm  = entries[issueIdx].imm;
    assign issueNick = entries[issueIdx].nick;
    assign issueRs1  = entries[issueIdx].rs1.data;
    assign issueRs2  = entries[issueIdx].rs2.data;

    // ----------------------------------------
    // wakeup, free on issue, write on dispatch
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                entries[i].busy <= 1'b0;
            end
        end else if (rdy) begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (entries[i].busy) begin
                    if (!entries[i].rs1Ready && cdbHit(entries[i].rs1)) begin
                        entries[i].rs1Ready <= 1'b1;
                        entries[i].rs1.data <= cdbValue(entries[i].rs1);
                    end
                    if (!entries[i].rs2Ready && cdbHit(entries[i].rs2)) begin
                        entries[i].rs2Ready <= 1'b1;
                        entries[i].rs2.data <= cdbValue(entries[i].rs2);
                    end
                end
            end
            if (issueEn) begin
                entries[issueIdx].busy <= 1'b0;
            end
            if (dispatchEn && !rsFull) begin
                entries[freeIdx] <= newEntry;  // never the issuing slot
            end
        end
    end

    // ----------------------------------------
    dispatchNotFull: assert property (@(posedge clk) disable iff (rst)
        rdy && dispatchEn |-> !rsFull)
        else $error("dispatch while reservation station is full");

    issueFreesEntry: assert property (@(posedge clk) disable iff (rst)
        rdy && issueEn |=> !busyVec[$past(issueIdx)])
        else $error("issued entry still busy after its issue");

endmodule

/* rsPkg.sv */
`include "execCluster_defs.svh"

package rsPkg;

    // tag view, producer nick in the low bits
    typedef struct packed {
        logic [`DATA_W-`NICK_W-1:0] upper;  // zero
        logic [`NICK_W-1:0]         nick;
    } opndTag_s;

    // meaning follows the companion ready bit
    typedef union packed {
        logic [`DATA_W-1:0] data;
        opndTag_s           tag;
    } operand_u;

    typedef struct packed {
        logic                busy;
        rvOpPkg::aluOp_e     op;
        logic [`ADDR_W-1:0]  pc;
        logic [`DATA_W-1:0]  imm;
        logic [`NICK_W-1:0]  nick;     // destination
        logic                rs1Ready;
        operand_u            rs1;
        logic                rs2Ready;
        operand_u            rs2;
    } rsEntry_s;

endpackage

/* rvOpPkg.sv */
package rvOpPkg;

    // one code per supported rv32i integer instruction
    typedef enum logic [4:0] {
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        ADDI,
        SLTI,
        SLTIU,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } aluOp_e;

    // redirect flag toward the rob
    typedef enum logic {
        NotJump = 1'b0,
        Jump    = 1'b1
    } jumpFlag_e;

endpackage
